/* common/matrix_alu_pkg.sv */
package matrix_alu_pkg;

    localparam int ELEM_W    = 16;
    localparam int DIM       = 4;
    localparam int WORD_W    = 256;
    localparam int ADDR_W    = 16;
    localparam int REG_IDX_W = 12;  // low address bits that pick a register

    // top address nibble the ALU answers to
    localparam logic [3:0] BLOCK_SEL = 4'h4;

    localparam logic [REG_IDX_W-1:0] REG_SRC1   = 12'd0;
    localparam logic [REG_IDX_W-1:0] REG_SRC2   = 12'd1;
    localparam logic [REG_IDX_W-1:0] REG_RESULT = 12'd2;
    localparam logic [REG_IDX_W-1:0] REG_OPCODE = 12'd3;
    localparam logic [REG_IDX_W-1:0] REG_STATUS = 12'd4;  // done in bit 0

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [7:0]        opcode_t;

    localparam opcode_t OP_MUL_4X4     = 8'h00;
    localparam opcode_t OP_MUL_4X2_2X4 = 8'h01;
    localparam opcode_t OP_MUL_2X4_4X2 = 8'h02;
    localparam opcode_t OP_ADD         = 8'h03;
    localparam opcode_t OP_SUB         = 8'h04;
    localparam opcode_t OP_TRANSPOSE   = 8'h05;
    localparam opcode_t OP_SCALE       = 8'h06;

    // one bus word seen either flat or as a 4x4 matrix
    // elem[r][c] sits at bits 16*(4r+c) upward
    typedef union packed {
        logic [WORD_W-1:0]             flat;
        elem_t [DIM-1:0][DIM-1:0]      elem;
    } matrix_word_u;

    typedef struct packed {
        matrix_word_u src1;
        matrix_word_u src2;
        opcode_t      opcode;
        logic         start;   // one cycle after an opcode write
    } operands_s;

endpackage

/* design/matrix_regs.sv */
`timescale 1ns/100ps

module matrix_regs (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [matrix_alu_pkg::ADDR_W-1:0] address,
    input  logic                              read_n,
    input  logic                              write_n,
    input  logic [matrix_alu_pkg::WORD_W-1:0] write_data,
    input  matrix_alu_pkg::matrix_word_u      result,
    input  logic                              done,
    output matrix_alu_pkg::operands_s         operands,
    output logic                              source_write,
    output logic [matrix_alu_pkg::WORD_W-1:0] read_data
);

    logic                                 selected;
    logic [matrix_alu_pkg::REG_IDX_W-1:0] reg_idx;
    logic                                 wr_sel;
    logic                                 rd_sel;

    // block select on the top nibble, register index below it
    assign selected = (address[matrix_alu_pkg::ADDR_W-1 -: 4] == matrix_alu_pkg::BLOCK_SEL);
    assign reg_idx  = address[matrix_alu_pkg::REG_IDX_W-1:0];
    assign wr_sel   = selected && !write_n;
    assign rd_sel   = selected && !read_n;

    // source and opcode registers, start and write pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operands     <= '0;
            source_write <= 1'b0;
        end else begin
            operands.start <= 1'b0;
            source_write   <= wr_sel;  // lets the result stage drop done
            if (wr_sel) begin
                case (reg_idx)
                    matrix_alu_pkg::REG_SRC1: begin
                        operands.src1.flat <= write_data;
                    end
                    matrix_alu_pkg::REG_SRC2: begin
                        operands.src2.flat <= write_data;
                    end
                    matrix_alu_pkg::REG_OPCODE: begin
                        operands.opcode <= write_data[$bits(matrix_alu_pkg::opcode_t)-1:0];
                        operands.start  <= 1'b1;
                    end
                    default: ;  // result and status are read only
                endcase
            end
        end
    end

    // combinational readback, zero when not addressed
    always_comb begin
        read_data = '0;
        if (rd_sel) begin
            case (reg_idx)
                matrix_alu_pkg::REG_SRC1: begin
                    read_data = operands.src1.flat;
                end
                matrix_alu_pkg::REG_SRC2: begin
                    read_data = operands.src2.flat;
                end
                matrix_alu_pkg::REG_RESULT: begin
                    read_data = result.flat;
                end
                matrix_alu_pkg::REG_OPCODE: begin
                    read_data[$bits(matrix_alu_pkg::opcode_t)-1:0] = operands.opcode;
                end
                matrix_alu_pkg::REG_STATUS: begin
                    read_data[0] = done;
                end
                default: begin
                    read_data = '0;
                end
            endcase
        end
    end

endmodule

/* matrix_product/matrix_product_unit.sv */
`timescale 1ns/100ps

module matrix_product_unit (
    input  matrix_alu_pkg::operands_s    operands,
    output matrix_alu_pkg::matrix_word_u product
);

    matrix_alu_pkg::matrix_word_u mul_4x4;
    matrix_alu_pkg::matrix_word_u mul_4x2_2x4;
    matrix_alu_pkg::matrix_word_u mul_2x4_4x2;
    matrix_alu_pkg::matrix_word_u scaled;

    // one row of a times one column of b, over the first depth terms
    function automatic matrix_alu_pkg::elem_t row_col(
        input matrix_alu_pkg::matrix_word_u a,
        input matrix_alu_pkg::matrix_word_u b,
        input int                           r,
        input int                           c,
        input int                           depth
    );
        matrix_alu_pkg::elem_t acc;
        acc = '0;
        for (int k = 0; k < depth; k++) begin
            acc = acc + a.elem[r][k] * b.elem[k][c];  // wraps at 16 bits
        end
        return acc;
    endfunction

    // 4x4 by 4x4 and 4x2 by 2x4, both fill the whole word
    always_comb begin
        for (int r = 0; r < matrix_alu_pkg::DIM; r++) begin
            for (int c = 0; c < matrix_alu_pkg::DIM; c++) begin
                mul_4x4.elem[r][c] =
                    row_col(operands.src1, operands.src2, r, c, matrix_alu_pkg::DIM);
                mul_4x2_2x4.elem[r][c] =
                    row_col(operands.src1, operands.src2, r, c, 2);
            end
        end
    end

    // 2x4 by 4x2 gives a 2x2, packed into row 0
    always_comb begin
        mul_2x4_4x2 = '0;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                mul_2x4_4x2.elem[0][2*r+c] =
                    row_col(operands.src1, operands.src2, r, c, matrix_alu_pkg::DIM);
            end
        end
    end

    // scalar is element [0][0] of source 2
    always_comb begin
        for (int r = 0; r < matrix_alu_pkg::DIM; r++) begin
            for (int c = 0; c < matrix_alu_pkg::DIM; c++) begin
                scaled.elem[r][c] = operands.src1.elem[r][c] * operands.src2.elem[0][0];
            end
        end
    end

    always_comb begin
        case (operands.opcode)
            matrix_alu_pkg::OP_MUL_4X4: begin
                product = mul_4x4;
            end
            matrix_alu_pkg::OP_MUL_4X2_2X4: begin
                product = mul_4x2_2x4;
            end
            matrix_alu_pkg::OP_MUL_2X4_4X2: begin
                product = mul_2x4_4x2;
            end
            matrix_alu_pkg::OP_SCALE: begin
                product = scaled;
            end
            default: begin
                product = '0;  // not a product op
            end
        endcase
    end

endmodule

/* design/matrix_elementwise_unit.sv */
`timescale 1ns/100ps

module matrix_elementwise_unit (
    input  matrix_alu_pkg::operands_s    operands,
    output matrix_alu_pkg::matrix_word_u elementwise
);

    matrix_alu_pkg::matrix_word_u sum;
    matrix_alu_pkg::matrix_word_u diff;
    matrix_alu_pkg::matrix_word_u transposed;

    // per element, so no carry crosses into the neighbour
    always_comb begin
        for (int r = 0; r < matrix_alu_pkg::DIM; r++) begin
            for (int c = 0; c < matrix_alu_pkg::DIM; c++) begin
                sum.elem[r][c]        = operands.src1.elem[r][c] + operands.src2.elem[r][c];
                diff.elem[r][c]       = operands.src1.elem[r][c] - operands.src2.elem[r][c];
                transposed.elem[r][c] = operands.src1.elem[c][r];  // source 1 only
            end
        end
    end

    always_comb begin
        case (operands.opcode)
            matrix_alu_pkg::OP_ADD: begin
                elementwise = sum;
            end
            matrix_alu_pkg::OP_SUB: begin
                elementwise = diff;
            end
            matrix_alu_pkg::OP_TRANSPOSE: begin
                elementwise = transposed;
            end
            default: begin
                elementwise = '0;
            end
        endcase
    end

endmodule

/* design/matrix_result_stage.sv */
`timescale 1ns/100ps

module matrix_result_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  matrix_alu_pkg::operands_s    operands,
    input  logic                         source_write,
    input  matrix_alu_pkg::matrix_word_u product,
    input  matrix_alu_pkg::matrix_word_u elementwise,
    output matrix_alu_pkg::matrix_word_u result,
    output logic                         done
);

    logic use_product;
    logic use_elementwise;

    // which unit owns the current opcode
    always_comb begin
        use_product     = 1'b0;
        use_elementwise = 1'b0;
        case (operands.opcode)
            matrix_alu_pkg::OP_MUL_4X4,
            matrix_alu_pkg::OP_MUL_4X2_2X4,
            matrix_alu_pkg::OP_MUL_2X4_4X2,
            matrix_alu_pkg::OP_SCALE:      use_product     = 1'b1;
            matrix_alu_pkg::OP_ADD,
            matrix_alu_pkg::OP_SUB,
            matrix_alu_pkg::OP_TRANSPOSE:  use_elementwise = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else if (operands.start) begin
            if (use_product) begin
                result <= product;
            end else if (use_elementwise) begin
                result <= elementwise;
            end
            done <= use_product || use_elementwise;  // unknown op keeps old result
        end else if (source_write) begin
            done <= 1'b0;  // new source data, result is stale
        end
    end

endmodule

/* design/matrix_alu.sv */
`timescale 1ns/100ps

module matrix_alu (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [matrix_alu_pkg::ADDR_W-1:0] address,
    input  logic                              read_n,
    input  logic                              write_n,
    input  logic [matrix_alu_pkg::WORD_W-1:0] write_data,
    output logic [matrix_alu_pkg::WORD_W-1:0] read_data
);

    matrix_alu_pkg::operands_s    operands;     // fanned out to both units
    matrix_alu_pkg::matrix_word_u product;
    matrix_alu_pkg::matrix_word_u elementwise;
    matrix_alu_pkg::matrix_word_u result;
    logic                         source_write;
    logic                         done;

    // bus side
    matrix_regs i_matrix_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .address      (address),
        .read_n       (read_n),
        .write_n      (write_n),
        .write_data   (write_data),
        .result       (result),
        .done         (done),
        .operands     (operands),
        .source_write (source_write),
        .read_data    (read_data)
    );

    // products and scale
    matrix_product_unit i_matrix_product_unit (
        .operands (operands),
        .product  (product)
    );

    // add, sub, transpose
    matrix_elementwise_unit i_matrix_elementwise_unit (
        .operands    (operands),
        .elementwise (elementwise)
    );

    matrix_result_stage i_matrix_result_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .operands     (operands),
        .source_write (source_write),
        .product      (product),
        .elementwise  (elementwise),
        .result       (result),
        .done         (done)
    );

endmodule

/* tb/matrix_alu_checker.sv */
`timescale 1ns/100ps

module matrix_alu_checker (
    input logic                              clk,
    input logic                              arst_n,
    input logic [matrix_alu_pkg::ADDR_W-1:0] address,
    input logic                              read_n,
    input logic                              write_n,
    input logic [matrix_alu_pkg::WORD_W-1:0] write_data,
    input logic [matrix_alu_pkg::WORD_W-1:0] read_data,
    input logic                              done
);

    logic        selected_write;
    logic        opcode_write;
    int unsigned fail_count = 0;  // read by the testbench

    assign selected_write = (address[matrix_alu_pkg::ADDR_W-1 -: 4] == matrix_alu_pkg::BLOCK_SEL)
                            && !write_n;
    assign opcode_write   = selected_write
                            && (address[matrix_alu_pkg::REG_IDX_W-1:0]
                                == matrix_alu_pkg::REG_OPCODE);

    // readback bus stays quiet without a read strobe
    idle_read_zero: assert property (@(posedge clk) disable iff (!arst_n)
        read_n |-> (read_data == '0))
        else begin
            fail_count++;
            $error("read_data is driven while read_n is high");
        end

    // done drops at the edge after the write, seen one sample later
    write_clears_done: assert property (@(posedge clk) disable iff (!arst_n)
        (selected_write && !opcode_write) |-> ##2 !done)
        else begin
            fail_count++;
            $error("done still high after a selected source write");
        end

    known_opcode_sets_done: assert property (@(posedge clk) disable iff (!arst_n)
        (opcode_write && (write_data[7:0] <= matrix_alu_pkg::OP_SCALE)) |-> ##2 done)
        else begin
            fail_count++;
            $error("done did not rise after a known opcode write");
        end

endmodule

bind matrix_alu matrix_alu_checker i_matrix_alu_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .address    (address),
    .read_n     (read_n),
    .write_n    (write_n),
    .write_data (write_data),
    .read_data  (read_data),
    .done       (done)
);

/* tb/matrix_alu_tb.sv */
`timescale 1ns/100ps

module matrix_alu_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_ROWS    = 16;
    localparam int DONE_POLLS  = 4;
    localparam int WATCHDOG_NS = NUM_ROWS * 8 * CLK_PERIOD * 2;

    typedef struct packed {
        logic [7:0]   opcode;
        logic [255:0] src1;
        logic [255:0] src2;
        logic [255:0] exp_result;
        logic         exp_done;
    } table_row_s;

    logic         clk;
    logic         arst_n;
    logic [15:0]  address;
    logic         read_n;
    logic         write_n;
    logic [255:0] write_data;
    logic [255:0] read_data;

    table_row_s rows [NUM_ROWS];
    integer     seed;

    matrix_alu i_matrix_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .address    (address),
        .read_n     (read_n),
        .write_n    (write_n),
        .write_data (write_data),
        .read_data  (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        wait (i_matrix_alu.i_matrix_alu_checker.fail_count != 0);
        stop_on_error($sformatf("assertion failed at %0d ns on the bus or done timing", $time));
    end

    function automatic logic [15:0] reg_addr(input logic [11:0] idx);
        return {matrix_alu_pkg::BLOCK_SEL, idx};
    endfunction

    // element r,c lives at bits 16*(4r+c) upward
    function automatic int unsigned elem_of(input logic [255:0] w, input int r, input int c);
        return {16'h0, w[16*(4*r+c) +: 16]};
    endfunction

    function automatic logic [255:0] fill_word(input logic [15:0] value);
        logic [255:0] w;
        for (int i = 0; i < 16; i++) begin
            w[16*i +: 16] = value;
        end
        return w;
    endfunction

    function automatic logic [255:0] identity_word();
        logic [255:0] w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            w[16*(5*i) +: 16] = 16'h0001;  // diagonal
        end
        return w;
    endfunction

    function automatic logic [255:0] ramp_word();
        logic [255:0] w;
        logic [15:0]  v;
        v = 16'h0003;
        for (int i = 0; i < 16; i++) begin
            w[16*i +: 16] = v;
            v = v + 16'h1357;
        end
        return w;
    endfunction

    function automatic logic [255:0] random_word();
        logic [255:0] w;
        for (int i = 0; i < 8; i++) begin
            w[32*i +: 32] = $random(seed);
        end
        return w;
    endfunction

    // reference model, prev is what an unknown opcode leaves behind
    function automatic logic [255:0] model_result(input logic [7:0] op, input logic [255:0] a,
                                                  input logic [255:0] b, input logic [255:0] prev);
        logic [255:0] y;
        int unsigned  acc;
        y = '0;
        case (op)
            matrix_alu_pkg::OP_MUL_4X4, matrix_alu_pkg::OP_MUL_4X2_2X4: begin
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        acc = 0;
                        for (int k = 0; k < ((op == matrix_alu_pkg::OP_MUL_4X4) ? 4 : 2); k++) begin
                            acc = acc + elem_of(a, r, k) * elem_of(b, k, c);
                        end
                        y[16*(4*r+c) +: 16] = acc[15:0];
                    end
                end
            end
            matrix_alu_pkg::OP_MUL_2X4_4X2: begin
                for (int r = 0; r < 2; r++) begin
                    for (int c = 0; c < 2; c++) begin
                        acc = 0;
                        for (int k = 0; k < 4; k++) begin
                            acc = acc + elem_of(a, r, k) * elem_of(b, k, c);
                        end
                        y[16*(2*r+c) +: 16] = acc[15:0];  // 2x2 packed into row 0
                    end
                end
            end
            matrix_alu_pkg::OP_ADD: begin
                for (int i = 0; i < 16; i++) begin
                    y[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
                end
            end
            matrix_alu_pkg::OP_SUB: begin
                for (int i = 0; i < 16; i++) begin
                    y[16*i +: 16] = a[16*i +: 16] - b[16*i +: 16];
                end
            end
            matrix_alu_pkg::OP_TRANSPOSE: begin
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        y[16*(4*r+c) +: 16] = a[16*(4*c+r) +: 16];
                    end
                end
            end
            matrix_alu_pkg::OP_SCALE: begin
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        acc = elem_of(a, r, c) * elem_of(b, 0, 0);
                        y[16*(4*r+c) +: 16] = acc[15:0];
                    end
                end
            end
            default: y = prev;
        endcase
        return y;
    endfunction

    task automatic set_row(input int idx, input logic [7:0] op, input logic [255:0] a,
                           input logic [255:0] b);
        rows[idx].opcode = op;
        rows[idx].src1   = a;
        rows[idx].src2   = b;
    endtask

    task automatic build_table();
        logic [255:0] prev;
        set_row(0,  matrix_alu_pkg::OP_MUL_4X4,     identity_word(), random_word());
        set_row(1,  matrix_alu_pkg::OP_MUL_4X4,     random_word(), random_word());
        set_row(2,  matrix_alu_pkg::OP_MUL_4X4,     fill_word(16'hffff), fill_word(16'hffff));
        set_row(3,  matrix_alu_pkg::OP_MUL_4X2_2X4, random_word(), random_word());
        set_row(4,  matrix_alu_pkg::OP_MUL_2X4_4X2, random_word(), random_word());
        set_row(5,  matrix_alu_pkg::OP_MUL_2X4_4X2, ramp_word(), fill_word(16'hffff));
        set_row(6,  matrix_alu_pkg::OP_ADD,         fill_word(16'hffff), fill_word(16'h0001));
        set_row(7,  matrix_alu_pkg::OP_ADD,         random_word(), random_word());
        set_row(8,  matrix_alu_pkg::OP_SUB,         random_word(), random_word());
        set_row(9,  matrix_alu_pkg::OP_SUB,         '0, fill_word(16'h0001));
        set_row(10, matrix_alu_pkg::OP_TRANSPOSE,   ramp_word(), random_word());
        set_row(11, matrix_alu_pkg::OP_TRANSPOSE,   random_word(), '0);
        set_row(12, matrix_alu_pkg::OP_SCALE,       random_word(), random_word());
        set_row(13, 8'ha5,                          random_word(), random_word());
        set_row(14, matrix_alu_pkg::OP_SCALE,       ramp_word(), identity_word());
        set_row(15, 8'h07,                          random_word(), random_word());
        prev = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i].exp_result = model_result(rows[i].opcode, rows[i].src1, rows[i].src2, prev);
            rows[i].exp_done   = (rows[i].opcode <= matrix_alu_pkg::OP_SCALE);
            prev               = rows[i].exp_result;
        end
    endtask

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // one bus cycle each, the next access takes over the strobes
    task automatic bus_write(input logic [15:0] addr, input logic [255:0] data);
        @(negedge clk);
        address    = addr;
        write_data = data;
        write_n    = 1'b0;
        read_n     = 1'b1;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [255:0] data);
        @(negedge clk);
        address = addr;
        write_n = 1'b1;
        read_n  = 1'b0;
        #1;  // combinational readback has settled
        data = read_data;
    endtask

    task automatic check_read(input logic [15:0] addr, input string name,
                              input logic [255:0] expected);
        logic [255:0] actual;
        bus_read(addr, actual);
        assert (actual === expected)
        else stop_on_error($sformatf("MISMATCH at %0d ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
    endtask

    task automatic await_status(input logic expect_done);
        logic [255:0] status;
        logic         seen;
        seen = 1'b0;
        for (int i = 0; i < DONE_POLLS && !seen; i++) begin
            bus_read(reg_addr(matrix_alu_pkg::REG_STATUS), status);
            seen = status[0];
        end
        if (expect_done) begin
            assert (seen)
            else stop_on_error($sformatf("timeout at %0d ns: done never rose after opcode write",
                                         $time));
        end
        assert (status === {255'b0, expect_done})
        else stop_on_error($sformatf("MISMATCH at %0d ns: status expected %h, got %h",
                                     $time, {255'b0, expect_done}, status));
    endtask

    initial begin
        table_row_s last;
        seed       = 54998;
        arst_n     = 1'b0;
        address    = '0;
        read_n     = 1'b1;
        write_n    = 1'b1;
        write_data = '0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_read(reg_addr(matrix_alu_pkg::REG_SRC1),   "src1",   '0);
        check_read(reg_addr(matrix_alu_pkg::REG_SRC2),   "src2",   '0);
        check_read(reg_addr(matrix_alu_pkg::REG_RESULT), "result", '0);
        check_read(reg_addr(matrix_alu_pkg::REG_OPCODE), "opcode", '0);
        check_read(reg_addr(matrix_alu_pkg::REG_STATUS), "status", '0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            bus_write(reg_addr(matrix_alu_pkg::REG_SRC1), rows[i].src1);
            bus_write(reg_addr(matrix_alu_pkg::REG_SRC2), rows[i].src2);
            check_read(reg_addr(matrix_alu_pkg::REG_STATUS), "status", '0);  // dropped by writes
            bus_write(reg_addr(matrix_alu_pkg::REG_OPCODE), {248'b0, rows[i].opcode});
            await_status(rows[i].exp_done);
            check_read(reg_addr(matrix_alu_pkg::REG_RESULT), "result", rows[i].exp_result);
        end

        // wrong top nibble must neither write nor start
        last = rows[NUM_ROWS-1];
        bus_write({4'h5, matrix_alu_pkg::REG_SRC1}, ~last.src1);
        bus_write({4'h5, matrix_alu_pkg::REG_OPCODE}, {248'b0, matrix_alu_pkg::OP_ADD});
        check_read({4'h5, matrix_alu_pkg::REG_SRC1}, "read_data", '0);
        check_read(reg_addr(matrix_alu_pkg::REG_SRC1),   "src1",   last.src1);
        check_read(reg_addr(matrix_alu_pkg::REG_SRC2),   "src2",   last.src2);
        check_read(reg_addr(matrix_alu_pkg::REG_OPCODE), "opcode", {248'b0, last.opcode});
        check_read(reg_addr(matrix_alu_pkg::REG_STATUS), "status", '0);
        check_read(reg_addr(matrix_alu_pkg::REG_RESULT), "result", last.exp_result);
        @(negedge clk);
        read_n = 1'b1;
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* matrix_alu.f */
common/matrix_alu_pkg.sv
design/matrix_regs.sv
matrix_product/matrix_product_unit.sv
design/matrix_elementwise_unit.sv
design/matrix_result_stage.sv
design/matrix_alu.sv
tb/matrix_alu_checker.sv
tb/matrix_alu_tb.sv

/* Bender.yml */
package:
  name: matrix_alu

sources:
  - files:
      - common/matrix_alu_pkg.sv
      - design/matrix_regs.sv
      - matrix_product/matrix_product_unit.sv
      - design/matrix_elementwise_unit.sv
      - design/matrix_result_stage.sv
      - design/matrix_alu.sv
  - target: test
    files:
      - tb/matrix_alu_checker.sv
      - tb/matrix_alu_tb.sv
